//--- div_cfg.svh
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// operand and result word width
`define DIV_WIDTH 32

// holds any bit position 0..31 and any step count up to 32
`define DIV_CNT_WIDTH 6

// upper bound on cycles from start to done, with margin
`define DIV_TIMEOUT_CYCLES 64

`endif

//--- div_data_pkg.sv
`include "div_cfg.svh"

package div_data_pkg;

    // one operand or result word
    typedef logic [`DIV_WIDTH-1:0] div_word_t;

    // what the environment hands in with start
    typedef struct packed {
        div_word_t dividend;
        div_word_t divisor;
        logic      is_signed;
    } div_operands_t;

    // prepared job, magnitudes plus what is needed to restore signs
    typedef struct packed {
        div_word_t                 dividend_mag;
        div_word_t                 divisor_mag;
        logic [`DIV_CNT_WIDTH-1:0] dividend_msb;
        logic [`DIV_CNT_WIDTH-1:0] divisor_msb;
        logic                      neg_quot;
        logic                      neg_rem;
        logic                      early_out;
    } div_job_t;

    typedef struct packed {
        div_word_t quotient;
        div_word_t remainder;
    } div_result_t;

endpackage

//--- div_ctrl_pkg.sv
`include "div_cfg.svh"

package div_ctrl_pkg;

    // bit position or remaining step count
    typedef logic [`DIV_CNT_WIDTH-1:0] div_pos_t;

    // step loop sequencer
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ALIGN  = 2'd1,
        STEP   = 2'd2,
        FINISH = 2'd3
    } div_state_e;

endpackage

//--- div_operand_decode.sv
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_operand_decode
    import div_data_pkg::*;
(
    input  logic          clk,
    input  logic          rstn,
    input  logic          start,
    input  logic          flush,
    input  logic          idle,
    input  div_operands_t operands,
    output div_job_t      job,
    output logic          job_valid
);

    // highest set bit, a zero word reports position 0
    function automatic logic [`DIV_CNT_WIDTH-1:0] lead_one(input div_word_t w);
        logic [`DIV_CNT_WIDTH-1:0] pos;
        pos = '0;
        for (int i = 0; i < `DIV_WIDTH; i++) begin
            if (w[i]) begin
                pos = i[`DIV_CNT_WIDTH-1:0];
            end
        end
        return pos;
    endfunction

    logic                      dividend_neg;
    logic                      divisor_neg;
    div_word_t                 dividend_mag;
    div_word_t                 divisor_mag;
    logic [`DIV_CNT_WIDTH-1:0] dividend_msb;
    logic [`DIV_CNT_WIDTH-1:0] divisor_msb;
    logic                      accept;

    // sign bits only count for signed operations
    assign dividend_neg = operands.is_signed & operands.dividend[`DIV_WIDTH-1];
    assign divisor_neg  = operands.is_signed & operands.divisor[`DIV_WIDTH-1];

    // min value maps onto itself, which reads correctly as unsigned magnitude
    assign dividend_mag = dividend_neg ? ~operands.dividend + 1'b1 : operands.dividend;
    assign divisor_mag  = divisor_neg ? ~operands.divisor + 1'b1 : operands.divisor;

    assign dividend_msb = lead_one(dividend_mag);
    assign divisor_msb  = lead_one(divisor_mag);

    // start while a job is queued or running is dropped
    assign accept = start & idle & ~job_valid & ~flush;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            job_valid <= 1'b0;
        end else begin
            job_valid <= accept;
        end
    end

    // job stays stable until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            job.dividend_mag <= dividend_mag;
            job.divisor_mag  <= divisor_mag;
            job.dividend_msb <= dividend_msb;
            job.divisor_msb  <= divisor_msb;
            job.neg_quot     <= dividend_neg ^ divisor_neg;
            job.neg_rem      <= dividend_neg;
            // divide by zero or divisor longer than dividend
            job.early_out    <= (divisor_mag == '0) | (divisor_msb > dividend_msb);
        end
    end

endmodule

//--- div_step_loop.sv
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_step_loop
    import div_data_pkg::*;
    import div_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  div_job_t    job,
    input  logic        job_valid,
    output logic        idle,
    output div_result_t mag_result,
    output logic        neg_quot,
    output logic        neg_rem,
    output logic        mag_valid
);

    div_state_e state;
    div_state_e state_nxt;

    // partial remainder, aligned divisor, quotient bits, steps left
    div_word_t  rem_q;
    div_word_t  dvs_q;
    div_word_t  quot_q;
    div_pos_t   cnt_q;

    div_pos_t   shift_amt;
    logic       fits;
    div_word_t  rem_diff;

    // only meaningful when the job is not an early-out
    assign shift_amt = job.dividend_msb - job.divisor_msb;

    assign fits     = (rem_q >= dvs_q);
    assign rem_diff = rem_q - dvs_q;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (job_valid) begin
                    state_nxt = ALIGN;
                end
            end
            ALIGN: begin
                state_nxt = job.early_out ? FINISH : STEP;
            end
            STEP: begin
                // last of shift_amt + 1 steps
                if (cnt_q == '0) begin
                    state_nxt = FINISH;
                end
            end
            FINISH: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else if (flush) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (job_valid) begin
                    neg_quot <= job.neg_quot;
                    neg_rem  <= job.neg_rem;
                end
            end
            ALIGN: begin
                // early-out leaves quotient 0 and remainder = dividend
                rem_q  <= job.dividend_mag;
                quot_q <= '0;
                // line up the divisor's leading one with the dividend's
                dvs_q  <= job.divisor_mag << shift_amt;
                cnt_q  <= shift_amt;
            end
            STEP: begin
                if (fits) begin
                    rem_q <= rem_diff;
                end
                quot_q <= {quot_q[`DIV_WIDTH-2:0], fits};
                dvs_q  <= dvs_q >> 1;
                cnt_q  <= cnt_q - 1'b1;
            end
            default: begin
                rem_q <= rem_q;
            end
        endcase
    end

    assign idle      = (state == IDLE);
    assign mag_valid = (state == FINISH);

    assign mag_result.quotient  = quot_q;
    assign mag_result.remainder = rem_q;

endmodule

//--- div_sign_fix.sv
`timescale 1ns/1ps

module div_sign_fix
    import div_data_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  div_result_t mag_result,
    input  logic        neg_quot,
    input  logic        neg_rem,
    input  logic        mag_valid,
    output div_result_t result,
    output logic        done
);

    div_result_t fixed;
    logic        take;

    // quotient truncates toward zero, remainder follows the dividend
    assign fixed.quotient  = neg_quot ? ~mag_result.quotient + 1'b1
                                      : mag_result.quotient;
    assign fixed.remainder = neg_rem ? ~mag_result.remainder + 1'b1
                                     : mag_result.remainder;

    // a flush in the finish cycle kills the result
    assign take = mag_valid & ~flush;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= take;
            // result holds until the next done
            if (take) begin
                result <= fixed;
            end
        end
    end

endmodule

//--- div_unit.sv
`timescale 1ns/1ps

module div_unit
    import div_data_pkg::*;
(
    input  logic          clk,
    input  logic          rstn,
    input  logic          start,
    input  logic          flush,
    input  div_operands_t operands,
    output logic          busy,
    output logic          done,
    output div_result_t   result
);

    div_job_t    job;
    logic        job_valid;
    logic        idle;
    div_result_t mag_result;
    logic        neg_quot;
    logic        neg_rem;
    logic        mag_valid;

    div_operand_decode div_operand_decode_inst (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .flush     (flush),
        .idle      (idle),
        .operands  (operands),
        .job       (job),
        .job_valid (job_valid)
    );

    div_step_loop div_step_loop_inst (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .job        (job),
        .job_valid  (job_valid),
        .idle       (idle),
        .mag_result (mag_result),
        .neg_quot   (neg_quot),
        .neg_rem    (neg_rem),
        .mag_valid  (mag_valid)
    );

    div_sign_fix div_sign_fix_inst (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .mag_result (mag_result),
        .neg_quot   (neg_quot),
        .neg_rem    (neg_rem),
        .mag_valid  (mag_valid),
        .result     (result),
        .done       (done)
    );

    // queued job counts as busy, drops with done as the loop returns to idle
    assign busy = ~idle | job_valid;

endmodule

//--- div_unit_chk.sv
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_unit_chk
    import div_ctrl_pkg::*;
(
    input logic clk,
    input logic rstn,
    input logic flush,
    input logic busy,
    input logic done
);

    // done is a single-cycle strobe
    done_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // a result only comes out of a running division
    done_after_busy: assert property (@(posedge clk) disable iff (!rstn)
        done |-> $past(busy))
        else $error("done rose without busy in the cycle before");

    flush_clears_busy: assert property (@(posedge clk) disable iff (!rstn)
        flush |=> !busy)
        else $error("busy still high in the cycle after flush");

    // no division runs longer than the timeout bound
    busy_bounded: assert property (@(posedge clk) disable iff (!rstn)
        $rose(busy) |-> ##[1:`DIV_TIMEOUT_CYCLES] !busy)
        else $error("busy did not fall within the timeout bound");

endmodule

bind div_unit div_unit_chk div_unit_chk_inst (
    .clk   (clk),
    .rstn  (rstn),
    .flush (flush),
    .busy  (busy),
    .done  (done)
);

//--- div_unit_tb.sv
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_unit_tb
    import div_data_pkg::*;
    import div_ctrl_pkg::*;
();

    localparam int TIMEOUT = `DIV_TIMEOUT_CYCLES;
    localparam int MAX_LAT = 36;
    localparam int N_MAX   = 24;

    logic          clk;
    logic          rstn;
    logic          start;
    logic          flush;
    div_operands_t operands;
    logic          busy;
    logic          done;
    div_result_t   result;

    // stimulus table, one index per directed case
    string         names[N_MAX];
    div_operands_t tbl_ops[N_MAX];
    div_result_t   tbl_exp[N_MAX];
    int            tbl_lat[N_MAX];
    int            n_cases;

    div_unit div_unit_inst (
        .clk      (clk),
        .rstn     (rstn),
        .start    (start),
        .flush    (flush),
        .operands (operands),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_result(input string name, input div_result_t exp,
                                input div_result_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected q=%h r=%h actual q=%h r=%h", name,
                     exp.quotient, exp.remainder, act.quotient, act.remainder);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input div_pos_t exp, input div_pos_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic add_case(input string name, input div_word_t dvd, input div_word_t dvs,
                            input logic sgn, input div_word_t q, input div_word_t r,
                            input int lat);
        names[n_cases]             = name;
        tbl_ops[n_cases].dividend  = dvd;
        tbl_ops[n_cases].divisor   = dvs;
        tbl_ops[n_cases].is_signed = sgn;
        tbl_exp[n_cases].quotient  = q;
        tbl_exp[n_cases].remainder = r;
        tbl_lat[n_cases]           = lat;
        n_cases++;
    endtask

    // cycles counts from the start edge, sampled on falling edges
    task automatic wait_done(input string name, inout int cycles);
        while (done !== 1'b1) begin
            if (cycles >= TIMEOUT) begin
                $display("%s: done never arrived", name);
                abort_run();
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic expect_quiet(input string name);
        for (int i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            check_flag({name, " no done"}, 1'b0, done);
            check_flag({name, " busy low"}, 1'b0, busy);
        end
    endtask

    task automatic run_division(input string name, input div_operands_t ops,
                                input div_result_t exp, input int lat);
        int cycles;
        @(posedge clk);
        start    <= 1'b1;
        operands <= ops;
        @(negedge clk);
        check_flag({name, " idle before start"}, 1'b0, busy);
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_flag({name, " busy after start"}, 1'b1, busy);
        cycles = 1;
        wait_done(name, cycles);
        check_flag({name, " busy at done"}, 1'b0, busy);
        check_result(name, exp, result);
        if (cycles > MAX_LAT) begin
            $display("%s: latency of %0d cycles is above %0d", name, cycles, MAX_LAT);
            abort_run();
        end
        if (lat >= 0) begin
            check_count({name, " latency"}, div_pos_t'(lat), div_pos_t'(cycles));
        end
    endtask

    initial begin
        div_operands_t ops;
        div_result_t   exp;
        int            seed;
        int            sh;
        int            cycles;

        clk      = 1'b0;
        rstn     = 1'b0;
        start    = 1'b0;
        flush    = 1'b0;
        operands = '0;
        n_cases  = 0;
        seed     = 32'ha491_c686;
        void'($urandom(seed));

        // unsigned, latency is msb difference plus 5
        add_case("u_100_7",    32'd100,        32'd7,          1'b0, 32'd14,       32'd2,      9);
        add_case("u_equal",    32'h1234_5678,  32'h1234_5678,  1'b0, 32'd1,        32'd0,      5);
        add_case("u_by_one",   32'hdead_beef,  32'd1,          1'b0, 32'hdead_beef, 32'd0,    36);
        add_case("u_wide",     32'hffff_ffff,  32'h0001_0000,  1'b0, 32'hffff,     32'hffff,  20);
        add_case("u_top_bit",  32'h8000_0000,  32'd3,          1'b0, 32'h2aaa_aaaa, 32'd2,    35);
        add_case("u_same_len", 32'd5,          32'd7,          1'b0, 32'd0,        32'd5,      5);
        // signed, quotient toward zero and remainder with the dividend's sign
        add_case("s_pos_pos",  32'd100,        32'd7,          1'b1, 32'd14,       32'd2,      9);
        add_case("s_neg_pos",  32'hffff_ff9c,  32'd7,          1'b1, 32'hffff_fff2, 32'hffff_fffe, 9);
        add_case("s_pos_neg",  32'd100,        32'hffff_fff9,  1'b1, 32'hffff_fff2, 32'd2,     9);
        add_case("s_neg_neg",  32'hffff_ff9c,  32'hffff_fff9,  1'b1, 32'd14,       32'hffff_fffe, 9);
        add_case("s_min_m1",   32'h8000_0000,  32'hffff_ffff,  1'b1, 32'h8000_0000, 32'd0,    36);
        // early-out takes exactly 4 cycles
        add_case("e_zero_u",   32'd12345,      32'd0,          1'b0, 32'd0,        32'd12345,  4);
        add_case("e_zero_s",   32'hffff_fffb,  32'd0,          1'b1, 32'd0,        32'hffff_fffb, 4);
        add_case("e_big_u",    32'd5,          32'd100,        1'b0, 32'd0,        32'd5,      4);
        add_case("e_big_s",    32'hffff_fff9,  32'd100,        1'b1, 32'd0,        32'hffff_fff9, 4);

        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset done", 1'b0, done);
        check_result("reset result", '0, result);

        for (int i = 0; i < n_cases; i++) begin
            run_division(names[i], tbl_ops[i], tbl_exp[i], tbl_lat[i]);
        end

        for (int i = 0; i < 40; i++) begin
            ops.is_signed = 1'($urandom % 2);
            ops.dividend  = $urandom;
            sh            = $urandom % 32;
            ops.divisor   = $urandom >> sh;
            if (ops.divisor == '0) begin
                ops.divisor = 32'd1;
            end
            if (ops.is_signed) begin
                exp.quotient  = $signed(ops.dividend) / $signed(ops.divisor);
                exp.remainder = $signed(ops.dividend) % $signed(ops.divisor);
            end else begin
                exp.quotient  = ops.dividend / ops.divisor;
                exp.remainder = ops.dividend % ops.divisor;
            end
            run_division($sformatf("rand_%0d", i), ops, exp, -1);
        end

        // starts while busy must be dropped
        ops = '{dividend: 32'd100, divisor: 32'd7, is_signed: 1'b0};
        @(posedge clk);
        start    <= 1'b1;
        operands <= ops;
        // second start right behind the first, job still queued
        @(posedge clk);
        operands <= '{dividend: 32'd200, divisor: 32'd10, is_signed: 1'b0};
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_flag("busy_start busy", 1'b1, busy);
        // third start in the last cycle before done of the 9-cycle division
        repeat (6) @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        cycles = 9;
        wait_done("busy_start", cycles);
        check_result("busy_start", '{quotient: 32'd14, remainder: 32'd2}, result);
        check_flag("busy_start busy at done", 1'b0, busy);
        expect_quiet("busy_start");

        // flush two cycles into a long division
        @(posedge clk);
        start    <= 1'b1;
        operands <= '{dividend: 32'hffff_ffff, divisor: 32'd1, is_signed: 1'b0};
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check_flag("flush busy", 1'b0, busy);
        expect_quiet("flush");
        run_division("after_flush", '{dividend: 32'd1000, divisor: 32'd9, is_signed: 1'b0},
                     '{quotient: 32'd111, remainder: 32'd1}, 11);

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- div_unit.f
+incdir+.
div_data_pkg.sv
div_ctrl_pkg.sv
div_operand_decode.sv
div_step_loop.sv
div_sign_fix.sv
div_unit.sv
div_unit_chk.sv
div_unit_tb.sv
